// ==== jelly_bus_pkg.sv ====
// ----------------------------------------
// bus package for the peripheral subsystem
// wishbone widths, region codes, register
// offsets and the byte-lane write merge
// ----------------------------------------

package jelly_bus_pkg;

	// wishbone classic, word address covers bits 31..2
	localparam int WB_ADR_WIDTH = 30;
	localparam int WB_DAT_WIDTH = 32;
	localparam int WB_SEL_WIDTH = 4;

	// address bits 31..24
	localparam logic [7:0] REGION_SRAM  = 8'h01;
	localparam logic [7:0] REGION_IRC   = 8'hf0;
	localparam logic [7:0] REGION_TIMER = 8'hf1;

	// timer word offsets
	localparam logic [1:0] TIMER_REG_CONTROL = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_REG_COUNTER = 2'd2;

	// interrupt controller word offsets
	localparam logic [1:0] IRC_REG_ENABLE    = 2'd0;
	localparam logic [1:0] IRC_REG_PENDING   = 2'd1;
	localparam logic [1:0] IRC_REG_PRIORITY  = 2'd2;
	localparam logic [1:0] IRC_REG_FACTOR_ID = 2'd3;

	// replace the selected byte lanes of cur with those of dat
	function automatic logic [WB_DAT_WIDTH-1:0] wb_merge(
		input logic [WB_DAT_WIDTH-1:0] cur,
		input logic [WB_DAT_WIDTH-1:0] dat,
		input logic [WB_SEL_WIDTH-1:0] sel
	);
		logic [WB_DAT_WIDTH-1:0] res;
		res = cur;
		for (int i = 0; i < WB_SEL_WIDTH; i++)
		begin
			if (sel[i])
				res[i*8 +: 8] = dat[i*8 +: 8];
		end
		return res;
	endfunction

endpackage

// ==== jelly_wb_decoder.sv ====
// ----------------------------------------
// wishbone address decoder
// region field to one-hot slave strobes,
// return data and ack muxed back to master
// ----------------------------------------

module jelly_wb_decoder
	(
		input  logic [jelly_bus_pkg::WB_ADR_WIDTH-1:0] m_adr_i,
		input  logic                                   m_stb_i,
		output logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] m_dat_o,
		output logic                                   m_ack_o,

		output logic                                   sram_stb_o,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] sram_dat_i,
		input  logic                                   sram_ack_i,

		output logic                                   irc_stb_o,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] irc_dat_i,
		input  logic                                   irc_ack_i,

		output logic                                   timer_stb_o,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] timer_dat_i,
		input  logic                                   timer_ack_i
	);

	import jelly_bus_pkg::*;

	// bits 31..24 of the byte address
	logic [7:0] region;
	assign region = m_adr_i[WB_ADR_WIDTH-1 -: 8];

	// one compare per slave
	assign sram_stb_o  = m_stb_i & (region == REGION_SRAM);
	assign irc_stb_o   = m_stb_i & (region == REGION_IRC);
	assign timer_stb_o = m_stb_i & (region == REGION_TIMER);

	// return path
	always_comb
	begin
		case (region)
			REGION_SRAM:
			begin
				m_dat_o = sram_dat_i;
				m_ack_o = sram_ack_i;
			end
			REGION_IRC:
			begin
				m_dat_o = irc_dat_i;
				m_ack_o = irc_ack_i;
			end
			REGION_TIMER:
			begin
				m_dat_o = timer_dat_i;
				m_ack_o = timer_ack_i;
			end
			default:
			begin
				// unmapped addresses are answered here in the same cycle
				m_dat_o = '0;
				m_ack_o = m_stb_i;
			end
		endcase
	end

	// no two slaves may be selected together
	always_comb
	begin
		assert ($onehot0({sram_stb_o, irc_stb_o, timer_stb_o}))
			else $error("decoder: more than one slave strobe active");
	end

endmodule

// ==== jelly_sram.sv ====
// ----------------------------------------
// on-chip SRAM, wishbone slave
// byte-lane writes, registered read data
// ----------------------------------------

module jelly_sram
	#(
		parameter int SRAM_ADR_WIDTH = 10
	)
	(
		input  logic                                   clk,
		input  logic                                   reset,

		input  logic [SRAM_ADR_WIDTH-1:0]              wb_adr_i,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_i,
		input  logic                                   wb_we_i,
		input  logic [jelly_bus_pkg::WB_SEL_WIDTH-1:0] wb_sel_i,
		input  logic                                   wb_stb_i,
		output logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_o,
		output logic                                   wb_ack_o
	);

	import jelly_bus_pkg::*;

	logic [WB_DAT_WIDTH-1:0] mem [0:2**SRAM_ADR_WIDTH-1];

	// first cycle of an access
	logic access;
	assign access = wb_stb_i & ~wb_ack_o;

	// storage and read port
	always_ff @(posedge clk)
	begin
		if (access)
		begin
			for (int i = 0; i < WB_SEL_WIDTH; i++)
			begin
				if (wb_we_i && wb_sel_i[i])
					mem[wb_adr_i][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
			end
			wb_dat_o <= mem[wb_adr_i];
		end
	end

	// one-cycle ack pulse
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= access;
	end

	assert property (@(posedge clk) disable iff (reset) wb_ack_o |-> $past(wb_stb_i))
		else $error("sram: ack without a preceding strobe");

endmodule

// ==== jelly_timer.sv ====
// ----------------------------------------
// interval timer, wishbone slave
// counts while enabled, pulses irq_o on a
// compare match and restarts from zero
// ----------------------------------------

module jelly_timer
	(
		input  logic                                   clk,
		input  logic                                   reset,

		input  logic [1:0]                             wb_adr_i,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_i,
		input  logic                                   wb_we_i,
		input  logic [jelly_bus_pkg::WB_SEL_WIDTH-1:0] wb_sel_i,
		input  logic                                   wb_stb_i,
		output logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_o,
		output logic                                   wb_ack_o,

		output logic                                   irq_o
	);

	import jelly_bus_pkg::*;

	logic                    enable;
	logic [WB_DAT_WIDTH-1:0] compare;
	logic [WB_DAT_WIDTH-1:0] counter;

	logic                    access;
	logic                    wr_en;
	logic                    match;
	logic [WB_DAT_WIDTH-1:0] ctrl_wdata;

	assign access     = wb_stb_i & ~wb_ack_o;
	assign wr_en      = access & wb_we_i;
	assign match      = (counter == compare);
	assign ctrl_wdata = wb_merge(WB_DAT_WIDTH'(enable), wb_dat_i, wb_sel_i);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			enable   <= 1'b0;
			compare  <= '0;
			counter  <= '0;
			irq_o    <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
		end
		else
		begin
			wb_ack_o <= access;
			irq_o    <= enable & match;

			// register writes
			if (wr_en && wb_adr_i == TIMER_REG_CONTROL)
				enable <= ctrl_wdata[0];
			if (wr_en && wb_adr_i == TIMER_REG_COMPARE)
				compare <= wb_merge(compare, wb_dat_i, wb_sel_i);

			// any write to the counter clears it
			if (wr_en && wb_adr_i == TIMER_REG_COUNTER)
				counter <= '0;
			else if (enable)
				counter <= match ? '0 : counter + 1'b1;

			// read data lines up with ack
			if (access)
			begin
				case (wb_adr_i)
					TIMER_REG_CONTROL: wb_dat_o <= WB_DAT_WIDTH'(enable);
					TIMER_REG_COMPARE: wb_dat_o <= compare;
					TIMER_REG_COUNTER: wb_dat_o <= counter;
					default:           wb_dat_o <= '0;
				endcase
			end
		end
	end

	// compare of zero matches every cycle, so only a longer interval is checked
	assert property (@(posedge clk) disable iff (reset)
			(irq_o && compare != '0) |=> !irq_o)
		else $error("timer: irq held for two cycles");

endmodule

// ==== jelly_irc.sv ====
// ----------------------------------------
// interrupt controller, wishbone slave
// pending latch, enable mask, one priority
// bit per factor, cpu request/acknowledge
// ----------------------------------------

module jelly_irc
	#(
		parameter int FACTOR_NUM = 3
	)
	(
		input  logic                                   clk,
		input  logic                                   reset,

		input  logic [FACTOR_NUM-1:0]                  interrupt_i,
		output logic                                   cpu_irq_o,
		input  logic                                   cpu_irq_ack_i,

		input  logic [1:0]                             wb_adr_i,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_i,
		input  logic                                   wb_we_i,
		input  logic [jelly_bus_pkg::WB_SEL_WIDTH-1:0] wb_sel_i,
		input  logic                                   wb_stb_i,
		output logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_o,
		output logic                                   wb_ack_o
	);

	import jelly_bus_pkg::*;

	localparam int ID_WIDTH = (FACTOR_NUM > 1) ? $clog2(FACTOR_NUM) : 1;

	logic [FACTOR_NUM-1:0]   enable;
	logic [FACTOR_NUM-1:0]   pending;
	logic [FACTOR_NUM-1:0]   prio;

	logic                    access;
	logic                    wr_en;
	logic [FACTOR_NUM-1:0]   active;
	logic [ID_WIDTH-1:0]     factor_id;
	logic [FACTOR_NUM-1:0]   clear;
	logic [WB_DAT_WIDTH-1:0] enable_wdata;
	logic [WB_DAT_WIDTH-1:0] prio_wdata;
	logic [WB_DAT_WIDTH-1:0] clear_wdata;

	assign access = wb_stb_i & ~wb_ack_o;
	assign wr_en  = access & wb_we_i;
	assign active = pending & enable;

	assign enable_wdata = wb_merge(WB_DAT_WIDTH'(enable), wb_dat_i, wb_sel_i);
	assign prio_wdata   = wb_merge(WB_DAT_WIDTH'(prio), wb_dat_i, wb_sel_i);
	assign clear_wdata  = wb_merge('0, wb_dat_i, wb_sel_i);

	// ----------------------------------------
	// factor selection
	// ----------------------------------------

	// scan from the top so the lowest index wins a tie
	always_comb
	begin
		factor_id = '0;
		for (int i = FACTOR_NUM - 1; i >= 0; i--)
		begin
			if (active[i])
				factor_id = ID_WIDTH'(i);
		end
		for (int i = FACTOR_NUM - 1; i >= 0; i--)
		begin
			if (active[i] && prio[i])
				factor_id = ID_WIDTH'(i);
		end
	end

	// write-one-clear from the bus, plus the cpu acknowledge
	always_comb
	begin
		clear = '0;
		if (wr_en && wb_adr_i == IRC_REG_PENDING)
			clear = clear_wdata[FACTOR_NUM-1:0];
		if (cpu_irq_ack_i)
			clear[factor_id] = 1'b1;
	end

	// ----------------------------------------
	// registers
	// ----------------------------------------

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			enable    <= '0;
			pending   <= '0;
			prio      <= '0;
			cpu_irq_o <= 1'b0;
			wb_ack_o  <= 1'b0;
			wb_dat_o  <= '0;
		end
		else
		begin
			wb_ack_o  <= access;
			// a new request beats a clear in the same cycle
			pending   <= (pending & ~clear) | interrupt_i;
			cpu_irq_o <= |active;

			if (wr_en && wb_adr_i == IRC_REG_ENABLE)
				enable <= enable_wdata[FACTOR_NUM-1:0];
			if (wr_en && wb_adr_i == IRC_REG_PRIORITY)
				prio <= prio_wdata[FACTOR_NUM-1:0];

			if (access)
			begin
				case (wb_adr_i)
					IRC_REG_ENABLE:    wb_dat_o <= WB_DAT_WIDTH'(enable);
					IRC_REG_PENDING:   wb_dat_o <= WB_DAT_WIDTH'(pending);
					IRC_REG_PRIORITY:  wb_dat_o <= WB_DAT_WIDTH'(prio);
					IRC_REG_FACTOR_ID: wb_dat_o <= WB_DAT_WIDTH'(factor_id);
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) cpu_irq_o |-> $past(|active))
		else $error("irc: cpu request without an enabled pending factor");

endmodule

// ==== jelly_periph_top.sv ====
// ----------------------------------------
// peripheral subsystem top
// decoder, SRAM, timer and interrupt
// controller on one wishbone port
// ----------------------------------------

module jelly_periph_top
	#(
		parameter int SRAM_ADR_WIDTH = 10,
		parameter int FACTOR_NUM     = 3
	)
	(
		input  logic                                   clk,
		input  logic                                   reset,

		input  logic [jelly_bus_pkg::WB_ADR_WIDTH-1:0] wb_adr_i,
		input  logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_i,
		input  logic                                   wb_we_i,
		input  logic [jelly_bus_pkg::WB_SEL_WIDTH-1:0] wb_sel_i,
		input  logic                                   wb_stb_i,
		output logic [jelly_bus_pkg::WB_DAT_WIDTH-1:0] wb_dat_o,
		output logic                                   wb_ack_o,

		input  logic [1:0]                             ext_irq_i,
		output logic                                   cpu_irq_o,
		input  logic                                   cpu_irq_ack_i
	);

	import jelly_bus_pkg::*;

	logic                    sram_stb;
	logic [WB_DAT_WIDTH-1:0] sram_dat;
	logic                    sram_ack;
	logic                    irc_stb;
	logic [WB_DAT_WIDTH-1:0] irc_dat;
	logic                    irc_ack;
	logic                    timer_stb;
	logic [WB_DAT_WIDTH-1:0] timer_dat;
	logic                    timer_ack;

	// factor 0 timer, factors 1 and 2 external lines
	logic                    timer_irq;
	logic [FACTOR_NUM-1:0]   irc_interrupt;
	assign irc_interrupt = FACTOR_NUM'({ext_irq_i, timer_irq});

	// ----------------------------------------
	// address decoder
	// ----------------------------------------

	jelly_wb_decoder i_decoder
	(
		.m_adr_i     (wb_adr_i),
		.m_stb_i     (wb_stb_i),
		.m_dat_o     (wb_dat_o),
		.m_ack_o     (wb_ack_o),
		.sram_stb_o  (sram_stb),
		.sram_dat_i  (sram_dat),
		.sram_ack_i  (sram_ack),
		.irc_stb_o   (irc_stb),
		.irc_dat_i   (irc_dat),
		.irc_ack_i   (irc_ack),
		.timer_stb_o (timer_stb),
		.timer_dat_i (timer_dat),
		.timer_ack_i (timer_ack)
	);

	// ----------------------------------------
	// slaves
	// ----------------------------------------

	jelly_sram #(.SRAM_ADR_WIDTH(SRAM_ADR_WIDTH)) i_sram
	(
		.clk      (clk),
		.reset    (reset),
		.wb_adr_i (wb_adr_i[SRAM_ADR_WIDTH-1:0]),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_sel_i (wb_sel_i),
		.wb_stb_i (sram_stb),
		.wb_dat_o (sram_dat),
		.wb_ack_o (sram_ack)
	);

	jelly_timer i_timer
	(
		.clk      (clk),
		.reset    (reset),
		.wb_adr_i (wb_adr_i[1:0]),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_sel_i (wb_sel_i),
		.wb_stb_i (timer_stb),
		.wb_dat_o (timer_dat),
		.wb_ack_o (timer_ack),
		.irq_o    (timer_irq)
	);

	jelly_irc #(.FACTOR_NUM(FACTOR_NUM)) i_irc
	(
		.clk           (clk),
		.reset         (reset),
		.interrupt_i   (irc_interrupt),
		.cpu_irq_o     (cpu_irq_o),
		.cpu_irq_ack_i (cpu_irq_ack_i),
		.wb_adr_i      (wb_adr_i[1:0]),
		.wb_dat_i      (wb_dat_i),
		.wb_we_i       (wb_we_i),
		.wb_sel_i      (wb_sel_i),
		.wb_stb_i      (irc_stb),
		.wb_dat_o      (irc_dat),
		.wb_ack_o      (irc_ack)
	);

endmodule

// ==== tb_jelly_periph.sv ====
// ----------------------------------------
// testbench for the peripheral subsystem
// acts as the wishbone master and the CPU
// interrupt acknowledge
// ----------------------------------------

module tb_jelly_periph;

	import jelly_bus_pkg::*;

	localparam int SRAM_AW   = 10;
	localparam int FACTORS   = 3;
	localparam int NUM_TESTS = 6;
	localparam int SB_WORDS  = 16;
	localparam int TIMER_CMP = 9;

	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_EQ   = 2'd1;
	localparam logic [1:0] CHK_LE   = 2'd2;

	logic                    clk;
	logic                    reset;
	logic [WB_ADR_WIDTH-1:0] wb_adr;
	logic [WB_DAT_WIDTH-1:0] wb_dat;
	logic                    wb_we;
	logic [WB_SEL_WIDTH-1:0] wb_sel;
	logic                    wb_stb;
	logic [WB_DAT_WIDTH-1:0] wb_dat_o;
	logic                    wb_ack_o;
	logic [1:0]              ext_irq;
	logic                    cpu_irq_o;
	logic                    cpu_irq_ack;

	// expected values and check windows
	logic [1:0]              chk_mode;
	logic [WB_DAT_WIDTH-1:0] chk_dat;
	logic                    mask_chk;
	logic                    step_chk;
	logic                    step_val;
	logic                    interval_chk;
	logic                    auto_ack;
	logic                    ack_req;
	logic                    irq_prev;
	int                      rises;
	int                      gap;

	logic [WB_DAT_WIDTH-1:0] sb_mem [0:2**SRAM_AW-1];
	logic [SRAM_AW-1:0]      sb_adr [0:SB_WORDS-1];

	jelly_periph_top #(.SRAM_ADR_WIDTH(SRAM_AW), .FACTOR_NUM(FACTORS)) DUT
	(
		.clk           (clk),
		.reset         (reset),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat),
		.wb_we_i       (wb_we),
		.wb_sel_i      (wb_sel),
		.wb_stb_i      (wb_stb),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.ext_irq_i     (ext_irq),
		.cpu_irq_o     (cpu_irq_o),
		.cpu_irq_ack_i (cpu_irq_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// address helpers and reference model
	// ----------------------------------------

	// region, 12 unused bits, 10-bit word index
	function automatic logic [WB_ADR_WIDTH-1:0] sram_adr(input logic [SRAM_AW-1:0] idx);
		return {REGION_SRAM, 12'h000, idx};
	endfunction

	function automatic logic [WB_ADR_WIDTH-1:0] irc_adr(input logic [1:0] off);
		return {REGION_IRC, 20'h00000, off};
	endfunction

	function automatic logic [WB_ADR_WIDTH-1:0] timer_adr(input logic [1:0] off);
		return {REGION_TIMER, 20'h00000, off};
	endfunction

	function automatic logic is_mapped(input logic [7:0] region);
		return region == REGION_SRAM || region == REGION_IRC || region == REGION_TIMER;
	endfunction

	// expected word after a write with byte selects
	function automatic logic [31:0] lane_update(input logic [31:0] old, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old & ~mask) | (dat & mask);
	endfunction

	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	// ----------------------------------------
	// bus master and interrupt stimulus
	// ----------------------------------------

	task automatic bus_write(input logic [WB_ADR_WIDTH-1:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		wb_adr <= adr;
		wb_dat <= dat;
		wb_sel <= sel;
		wb_we  <= 1'b1;
		wb_stb <= 1'b1;
		@(posedge clk);
		while (!wb_ack_o)
			@(posedge clk);
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(posedge clk);
	endtask

	task automatic bus_read(input logic [WB_ADR_WIDTH-1:0] adr, input logic [31:0] exp_dat,
			input logic [1:0] mode);
		wb_adr   <= adr;
		wb_sel   <= 4'hf;
		wb_we    <= 1'b0;
		wb_stb   <= 1'b1;
		chk_dat  <= exp_dat;
		chk_mode <= mode;
		@(posedge clk);
		while (!wb_ack_o)
			@(posedge clk);
		wb_stb   <= 1'b0;
		chk_mode <= CHK_NONE;
		@(posedge clk);
	endtask

	task automatic pulse_ext(input logic [1:0] lines);
		ext_irq <= lines;
		@(posedge clk);
		ext_irq <= 2'b00;
		@(posedge clk);
	endtask

	task automatic pulse_ack();
		ack_req <= 1'b1;
		@(posedge clk);
		ack_req <= 1'b0;
		@(posedge clk);
	endtask

	// the cpu side acknowledges each rise and measures the spacing of rises
	initial
	begin
		cpu_irq_ack = 1'b0;
		irq_prev    = 1'b0;
		rises       = 0;
		gap         = 0;
		forever
		begin
			@(posedge clk);
			irq_prev    <= cpu_irq_o;
			cpu_irq_ack <= ack_req || (auto_ack && cpu_irq_o && !irq_prev);
			if (!interval_chk)
			begin
				rises <= 0;
				gap   <= 0;
			end
			else if (cpu_irq_o && !irq_prev)
			begin
				rises <= rises + 1;
				gap   <= 1;
			end
			else
				gap <= gap + 1;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	assert property (@(posedge clk) disable iff (reset)
			(chk_mode == CHK_EQ && wb_ack_o) |-> (wb_dat_o == chk_dat))
		else
		begin
			$display("error at %0t: wb_dat_o = %h, expected %h", $time, $sampled(wb_dat_o),
				$sampled(chk_dat));
			stop_run();
		end

	assert property (@(posedge clk) disable iff (reset)
			(chk_mode == CHK_LE && wb_ack_o) |-> (wb_dat_o <= chk_dat))
		else
		begin
			$display("error at %0t: wb_dat_o = %0d, expected at most %0d", $time,
				$sampled(wb_dat_o), $sampled(chk_dat));
			stop_run();
		end

	// unmapped regions answer in the strobe cycle with zero data
	assert property (@(posedge clk) disable iff (reset)
			(wb_stb && !is_mapped(wb_adr[WB_ADR_WIDTH-1 -: 8])) |->
			(wb_ack_o && wb_dat_o == 32'h0))
		else
		begin
			$display("error at %0t: unmapped wb_ack_o = %b wb_dat_o = %h, expected 1 and 0",
				$time, $sampled(wb_ack_o), $sampled(wb_dat_o));
			stop_run();
		end

	assert property (@(posedge clk) disable iff (reset)
			(interval_chk && cpu_irq_o && !irq_prev && rises > 0) |-> (gap == TIMER_CMP + 1))
		else
		begin
			$display("error at %0t: cpu_irq_o interval = %0d, expected %0d", $time,
				$sampled(gap), TIMER_CMP + 1);
			stop_run();
		end

	assert property (@(posedge clk) disable iff (reset) mask_chk |-> !cpu_irq_o)
		else
		begin
			$display("error at %0t: cpu_irq_o = %b, expected 0", $time, $sampled(cpu_irq_o));
			stop_run();
		end

	// request follows an enable or pending write one cycle after its ack
	assert property (@(posedge clk) disable iff (reset)
			(step_chk && wb_ack_o) |=> (cpu_irq_o == step_val))
		else
		begin
			$display("error at %0t: cpu_irq_o = %b, expected %b", $time, $sampled(cpu_irq_o),
				$sampled(step_val));
			stop_run();
		end

	initial
	begin
		repeat (NUM_TESTS * 200) @(posedge clk);
		$display("timeout, the tests did not finish within %0d cycles", NUM_TESTS * 200);
		stop_run();
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial
	begin
		logic [31:0] d;
		logic [3:0]  sel;
		int          k;

		void'($urandom(59));
		reset        = 1'b1;
		wb_adr       = '0;
		wb_dat       = '0;
		wb_we        = 1'b0;
		wb_sel       = '0;
		wb_stb       = 1'b0;
		ext_irq      = 2'b00;
		chk_mode     = CHK_NONE;
		chk_dat      = '0;
		mask_chk     = 1'b0;
		step_chk     = 1'b0;
		step_val     = 1'b0;
		interval_chk = 1'b0;
		auto_ack     = 1'b0;
		ack_req      = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// random sram words, full writes first so no lane stays unknown
		for (int i = 0; i < SB_WORDS; i++)
		begin
			sb_adr[i] = 10'($urandom());
			d = $urandom();
			bus_write(sram_adr(sb_adr[i]), d, 4'hf);
			sb_mem[sb_adr[i]] = d;
		end
		for (int i = 0; i < 2 * SB_WORDS; i++)
		begin
			k   = int'($urandom_range(SB_WORDS - 1, 0));
			d   = $urandom();
			sel = 4'($urandom());
			bus_write(sram_adr(sb_adr[k]), d, sel);
			sb_mem[sb_adr[k]] = lane_update(sb_mem[sb_adr[k]], d, sel);
		end
		for (int i = 0; i < SB_WORDS; i++)
			bus_read(sram_adr(sb_adr[i]), sb_mem[sb_adr[i]], CHK_EQ);

		// unmapped region with the same low bits as an sram word
		bus_write({8'h7e, 12'h000, sb_adr[0]}, ~sb_mem[sb_adr[0]], 4'hf);
		bus_read({8'h7e, 12'h000, sb_adr[0]}, 32'h0, CHK_NONE);
		for (int i = 0; i < SB_WORDS; i++)
			bus_read(sram_adr(sb_adr[i]), sb_mem[sb_adr[i]], CHK_EQ);

		// timer interval through factor 0
		auto_ack     <= 1'b1;
		interval_chk <= 1'b1;
		bus_write(timer_adr(TIMER_REG_COMPARE), 32'(TIMER_CMP), 4'hf);
		bus_write(irc_adr(IRC_REG_ENABLE), 32'h1, 4'hf);
		bus_write(timer_adr(TIMER_REG_CONTROL), 32'h1, 4'hf);
		while (rises < 4)
			@(posedge clk);
		interval_chk <= 1'b0;
		bus_write(timer_adr(TIMER_REG_CONTROL), 32'h0, 4'hf);
		bus_read(timer_adr(TIMER_REG_COUNTER), 32'(TIMER_CMP), CHK_LE);
		auto_ack <= 1'b0;
		bus_write(irc_adr(IRC_REG_ENABLE), 32'h0, 4'hf);
		repeat (4) @(posedge clk);
		bus_write(irc_adr(IRC_REG_PENDING), 32'h7, 4'hf);
		repeat (3) @(posedge clk);

		// masked factor 1 stays pending without a request
		mask_chk <= 1'b1;
		pulse_ext(2'b01);
		bus_read(irc_adr(IRC_REG_PENDING), 32'h2, CHK_EQ);
		mask_chk <= 1'b0;
		step_chk <= 1'b1;
		step_val <= 1'b1;
		bus_write(irc_adr(IRC_REG_ENABLE), 32'h2, 4'hf);
		step_chk <= 1'b0;

		// priority between factors 1 and 2
		bus_write(irc_adr(IRC_REG_ENABLE), 32'h6, 4'hf);
		pulse_ext(2'b10);
		bus_read(irc_adr(IRC_REG_FACTOR_ID), 32'd1, CHK_EQ);
		bus_write(irc_adr(IRC_REG_PRIORITY), 32'h4, 4'hf);
		bus_read(irc_adr(IRC_REG_FACTOR_ID), 32'd2, CHK_EQ);
		pulse_ack();
		bus_read(irc_adr(IRC_REG_FACTOR_ID), 32'd1, CHK_EQ);
		bus_read(irc_adr(IRC_REG_PENDING), 32'h2, CHK_EQ);

		// write-one-clear drops the request
		step_chk <= 1'b1;
		step_val <= 1'b0;
		bus_write(irc_adr(IRC_REG_PENDING), 32'h7, 4'hf);
		step_chk <= 1'b0;
		bus_read(irc_adr(IRC_REG_PENDING), 32'h0, CHK_EQ);
		repeat (2) @(posedge clk);

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== jelly_periph.f ====
jelly_bus_pkg.sv
jelly_wb_decoder.sv
jelly_sram.sv
jelly_timer.sv
jelly_irc.sv
jelly_periph_top.sv
tb_jelly_periph.sv

// ==== Makefile ====
# Verilator simulation of the peripheral subsystem testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_jelly_periph -f jelly_periph.f
	./obj_dir/Vtb_jelly_periph

clean:
	rm -rf obj_dir
